// File: rtl/isa_pkg.sv
package isa_pkg;

	// One instruction word with two readings. The opcode view is used
	// while a handler runs and the raw view when the word is a handler
	// address fetched from the vector table.
	typedef union packed {
		struct packed {
			logic [5:0]  op;
			logic [25:0] rest;
		} fields;
		logic [31:0] raw;
	} instr_word_u;

	// Return from interrupt, opcode with all ones
	localparam logic [5:0] OP_RETI = 6'b111111;

	// Vector table base out of reset
	// spart slot sits at the base, spu slot one word above
	localparam logic [31:0] VEC_BASE_RESET = 32'h0000_0008;

endpackage

// File: rtl/int_reg_pkg.sv
package int_reg_pkg;

	// APB address width
	localparam int ADDR_W = 8;

	// Number of interrupt sources
	localparam int NUM_SRC = 2;

	// Bit positions inside the enable, pending and pick vectors
	localparam int SRC_SPART = 0;
	localparam int SRC_SPU   = 1;

	// Register map
	localparam logic [ADDR_W-1:0] REG_ENABLE   = 8'h00;
	localparam logic [ADDR_W-1:0] REG_PENDING  = 8'h04;
	localparam logic [ADDR_W-1:0] REG_VEC_BASE = 8'h08;
	localparam logic [ADDR_W-1:0] REG_RESUME   = 8'h0C;

endpackage

// File: rtl/int_apb_regs.sv
`timescale 1ns/1ps

module int_apb_regs (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [int_reg_pkg::ADDR_W-1:0]   paddr,
	input  logic [31:0]                      pwdata,
	input  logic [int_reg_pkg::NUM_SRC-1:0]  src_line,
	input  logic                             accept,
	input  logic [int_reg_pkg::NUM_SRC-1:0]  accept_src,
	input  logic [31:0]                      resume_pc,
	output logic [31:0]                      prdata,
	output logic                             pready,
	output logic                             pslverr,
	output logic [int_reg_pkg::NUM_SRC-1:0]  enable,
	output logic [int_reg_pkg::NUM_SRC-1:0]  pending,
	output logic [31:0]                      vec_base
);

	logic                            access;
	logic                            mapped;
	logic                            wr_ok;
	logic [int_reg_pkg::NUM_SRC-1:0] sw_clr;
	logic [int_reg_pkg::NUM_SRC-1:0] hw_clr;
	logic [31:2]                     vec_base_q;

	// Every transfer finishes in its access cycle
	assign pready = 1'b1;
	assign access = psel & penable;

	always_comb begin
		case (paddr)
			int_reg_pkg::REG_ENABLE,
			int_reg_pkg::REG_PENDING,
			int_reg_pkg::REG_VEC_BASE,
			int_reg_pkg::REG_RESUME: mapped = 1'b1;
			default:                 mapped = 1'b0;
		endcase
	end

	// Resume PC is read-only, so a write to it is an error as well
	assign pslverr = access & (~mapped | (pwrite & (paddr == int_reg_pkg::REG_RESUME)));
	assign wr_ok   = access & pwrite & ~pslverr;

	// Write-one-to-clear from software, accept strobe from the sequencer
	assign sw_clr = (wr_ok && paddr == int_reg_pkg::REG_PENDING) ?
		pwdata[int_reg_pkg::NUM_SRC-1:0] : '0;
	assign hw_clr = accept ? accept_src : '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			enable <= '0;
		end else if (wr_ok && paddr == int_reg_pkg::REG_ENABLE) begin
			enable <= pwdata[int_reg_pkg::NUM_SRC-1:0];
		end
	end

	// A new event on the line wins over a clear in the same cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~(sw_clr | hw_clr)) | src_line;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vec_base_q <= isa_pkg::VEC_BASE_RESET[31:2];
		end else if (wr_ok && paddr == int_reg_pkg::REG_VEC_BASE) begin
			vec_base_q <= pwdata[31:2];
		end
	end

	// Slots are word aligned
	assign vec_base = {vec_base_q, 2'b00};

	// Read mux, unmapped offsets return zero
	always_comb begin
		prdata = '0;
		case (paddr)
			int_reg_pkg::REG_ENABLE:   prdata[int_reg_pkg::NUM_SRC-1:0] = enable;
			int_reg_pkg::REG_PENDING:  prdata[int_reg_pkg::NUM_SRC-1:0] = pending;
			int_reg_pkg::REG_VEC_BASE: prdata = vec_base;
			int_reg_pkg::REG_RESUME:   prdata = resume_pc;
			default:                   prdata = '0;
		endcase
	end

endmodule

// File: rtl/int_fsm.sv
`timescale 1ns/1ps

module int_fsm (
	input  logic        clk,
	input  logic        rst,
	input  logic        any_req,
	input  logic [31:0] instruction,
	input  logic        expired,
	output logic        accept,
	output logic        load_pc,
	output logic        capture_handler,
	output logic        start_drain,
	output logic        int_wait,
	output logic        int_run,
	output logic        int_done
);

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_VECTOR = 3'd1;
	localparam logic [2:0] S_FETCH  = 3'd2;
	localparam logic [2:0] S_DRAIN  = 3'd3;
	localparam logic [2:0] S_RUN    = 3'd4;

	logic [2:0]           state;
	logic [2:0]           next_state;
	isa_pkg::instr_word_u instr_w;

	assign instr_w = instruction;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state      = state;
		accept          = 1'b0;
		load_pc         = 1'b0;
		capture_handler = 1'b0;
		start_drain     = 1'b0;
		int_wait        = 1'b0;
		int_run         = 1'b0;
		int_done        = 1'b0;

		case (state)
			S_IDLE: begin
				// Stall starts in the same cycle the request is taken
				if (any_req) begin
					accept     = 1'b1;
					int_wait   = 1'b1;
					next_state = S_VECTOR;
				end
			end
			S_VECTOR: begin
				// Fetch reads the vector slot this cycle
				load_pc    = 1'b1;
				int_wait   = 1'b1;
				next_state = S_FETCH;
			end
			S_FETCH: begin
				capture_handler = 1'b1;
				start_drain     = 1'b1;
				int_wait        = 1'b1;
				next_state      = S_DRAIN;
			end
			S_DRAIN: begin
				// Older instructions leave the pipeline
				int_wait = 1'b1;
				if (expired) begin
					next_state = S_RUN;
				end
			end
			S_RUN: begin
				int_run = 1'b1;
				if (instr_w.fields.op == isa_pkg::OP_RETI) begin
					int_done   = 1'b1;
					next_state = S_IDLE;
				end
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

endmodule

// File: rtl/drain_timer.sv
`timescale 1ns/1ps

module drain_timer #(
	parameter logic [3:0] DRAIN_CYCLES = 4'd3
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic expired
);

	logic [3:0] count;

	// Loads on start, then counts down and rests at zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= 4'd0;
		end else if (start) begin
			count <= DRAIN_CYCLES;
		end else if (count != 4'd0) begin
			count <= count - 4'd1;
		end
	end

	// Last drain cycle
	assign expired = (count == 4'd1);

endmodule

// File: rtl/int_capture.sv
`timescale 1ns/1ps

module int_capture (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [int_reg_pkg::NUM_SRC-1:0] enable,
	input  logic [int_reg_pkg::NUM_SRC-1:0] pending,
	input  logic                            accept,
	input  logic                            take_branch,
	input  logic [31:0]                     pc_curr,
	input  logic [31:0]                     pc_branch,
	input  logic [31:0]                     vec_base,
	input  logic                            load_pc,
	input  logic                            capture_handler,
	input  logic [31:0]                     instruction,
	output logic                            any_req,
	output logic [int_reg_pkg::NUM_SRC-1:0] accept_src,
	output logic [31:0]                     pc_resume,
	output logic [31:0]                     pc_int
);

	logic [int_reg_pkg::NUM_SRC-1:0] req;
	logic                            src_q;
	logic [31:0]                     vec_addr;
	isa_pkg::instr_word_u            instr_w;
	logic [31:0]                     handler_q;

	assign req     = pending & enable;
	assign any_req = |req;

	// Fixed priority, spart ahead of spu
	assign accept_src[int_reg_pkg::SRC_SPART] = req[int_reg_pkg::SRC_SPART];
	assign accept_src[int_reg_pkg::SRC_SPU]   = req[int_reg_pkg::SRC_SPU] &
		~req[int_reg_pkg::SRC_SPART];

	// Source and return PC are held for the whole interrupt
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			src_q     <= 1'b0;
			pc_resume <= '0;
		end else if (accept) begin
			src_q     <= accept_src[int_reg_pkg::SRC_SPU];
			pc_resume <= take_branch ? pc_branch : pc_curr;
		end
	end

	// One word per slot above the base
	assign vec_addr = vec_base + {29'd0, src_q, 2'b00};

	assign instr_w = instruction;

	always_ff @(posedge clk) begin
		if (capture_handler) begin
			handler_q <= instr_w.raw;
		end
	end

	assign pc_int = load_pc ? vec_addr : handler_q;

endmodule

// File: rtl/int_ctrl_top.sv
`timescale 1ns/1ps

module int_ctrl_top #(
	parameter logic [3:0] DRAIN_CYCLES = 4'd3
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           spart_int,
	input  logic                           spu_int,
	input  logic [31:0]                    pc_curr,
	input  logic                           take_branch,
	input  logic [31:0]                    pc_branch,
	input  logic [31:0]                    instruction,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [int_reg_pkg::ADDR_W-1:0] paddr,
	input  logic [31:0]                    pwdata,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr,
	output logic [31:0]                    pc_int,
	output logic [31:0]                    pc_resume,
	output logic                           int_wait,
	output logic                           int_run,
	output logic                           int_done
);

	logic [int_reg_pkg::NUM_SRC-1:0] src_line;
	logic [int_reg_pkg::NUM_SRC-1:0] enable;
	logic [int_reg_pkg::NUM_SRC-1:0] pending;
	logic [int_reg_pkg::NUM_SRC-1:0] accept_src;
	logic [31:0]                     vec_base;
	logic                            any_req;
	logic                            accept;
	logic                            load_pc;
	logic                            capture_handler;
	logic                            start_drain;
	logic                            expired;

	// Peripheral lines in source order
	assign src_line[int_reg_pkg::SRC_SPART] = spart_int;
	assign src_line[int_reg_pkg::SRC_SPU]   = spu_int;

	int_apb_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.src_line   (src_line),
		.accept     (accept),
		.accept_src (accept_src),
		.resume_pc  (pc_resume),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.enable     (enable),
		.pending    (pending),
		.vec_base   (vec_base)
	);

	int_fsm u_fsm (
		.clk             (clk),
		.rst             (rst),
		.any_req         (any_req),
		.instruction     (instruction),
		.expired         (expired),
		.accept          (accept),
		.load_pc         (load_pc),
		.capture_handler (capture_handler),
		.start_drain     (start_drain),
		.int_wait        (int_wait),
		.int_run         (int_run),
		.int_done        (int_done)
	);

	drain_timer #(
		.DRAIN_CYCLES (DRAIN_CYCLES)
	) u_timer (
		.clk     (clk),
		.rst     (rst),
		.start   (start_drain),
		.expired (expired)
	);

	int_capture u_capture (
		.clk             (clk),
		.rst             (rst),
		.enable          (enable),
		.pending         (pending),
		.accept          (accept),
		.take_branch     (take_branch),
		.pc_curr         (pc_curr),
		.pc_branch       (pc_branch),
		.vec_base        (vec_base),
		.load_pc         (load_pc),
		.capture_handler (capture_handler),
		.instruction     (instruction),
		.any_req         (any_req),
		.accept_src      (accept_src),
		.pc_resume       (pc_resume),
		.pc_int          (pc_int)
	);

endmodule

// File: tests/int_ctrl_table.svh
`ifndef INT_CTRL_TABLE_SVH
`define INT_CTRL_TABLE_SVH

// Columns: pulse, enable, clear, base, pc_curr, take_branch, pc_branch, handler,
// run cycles, random, services, first vector, second vector, pending after
task automatic load_table();
	// Single spart request on the reset base
	add_row(2'b01, 2'b01, 2'b00, 32'h0000_0008, 32'h0000_1000, 1'b0, 32'h0000_2000,
		32'h0000_4000, 2, 1'b0, 2'd1, 32'h0000_0008, 32'h0, 2'b00);
	// Spu after moving the base, low bits are dropped
	add_row(2'b10, 2'b10, 2'b00, 32'h0000_0103, 32'h0000_1100, 1'b1, 32'h0000_3300,
		32'h0000_5200, 4, 1'b0, 2'd1, 32'h0000_0104, 32'h0, 2'b00);
	// Both lines at once, spart first and spu right after it
	add_row(2'b11, 2'b11, 2'b00, 32'h0000_0200, 32'h0000_1200, 1'b0, 32'h0000_4000,
		32'h0000_6000, 1, 1'b0, 2'd2, 32'h0000_0200, 32'h0000_0204, 2'b00);
	// Spu masked, stays pending
	add_row(2'b10, 2'b01, 2'b00, 32'h0000_0200, 32'h0000_1300, 1'b0, 32'h0000_4400,
		32'h0000_6600, 1, 1'b0, 2'd0, 32'h0, 32'h0, 2'b10);
	// Clear it, then enable both, nothing is served
	add_row(2'b00, 2'b11, 2'b10, 32'h0000_0200, 32'h0000_1400, 1'b0, 32'h0000_4800,
		32'h0000_6800, 1, 1'b0, 2'd0, 32'h0, 32'h0, 2'b00);
	// Random PCs and handler words
	add_row(2'b01, 2'b11, 2'b00, 32'h0000_0040, 32'h0, 1'b1, 32'h0,
		32'h0, 3, 1'b1, 2'd1, 32'h0000_0040, 32'h0, 2'b00);
	add_row(2'b10, 2'b11, 2'b00, 32'h0000_0040, 32'h0, 1'b0, 32'h0,
		32'h0, 1, 1'b1, 2'd1, 32'h0000_0044, 32'h0, 2'b00);
	add_row(2'b01, 2'b01, 2'b00, 32'h0000_0080, 32'h0, 1'b0, 32'h0,
		32'h0, 2, 1'b1, 2'd1, 32'h0000_0080, 32'h0, 2'b00);
endtask

`endif

// File: tests/int_ctrl_tb.sv
`timescale 1ns/1ps

module int_ctrl_tb;

	localparam logic [3:0]  DRAIN     = 4'd3;
	localparam int          MAX_ROWS  = 16;
	// Opcode field all ones, remainder zero
	localparam logic [31:0] RETI_WORD = 32'hfc00_0000;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic        clk;
	logic        rst;
	logic        spart_int;
	logic        spu_int;
	logic [31:0] pc_curr;
	logic        take_branch;
	logic [31:0] pc_branch;
	logic [31:0] instruction;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [31:0] pc_int;
	logic [31:0] pc_resume;
	logic        int_wait;
	logic        int_run;
	logic        int_done;

	logic [1:0]  row_pulse [MAX_ROWS];
	logic [1:0]  row_en [MAX_ROWS];
	logic [1:0]  row_clr [MAX_ROWS];
	logic [31:0] row_base [MAX_ROWS];
	logic [31:0] row_pc_c [MAX_ROWS];
	logic        row_br [MAX_ROWS];
	logic [31:0] row_pc_b [MAX_ROWS];
	logic [31:0] row_handler [MAX_ROWS];
	int          row_runs [MAX_ROWS];
	logic        row_rnd [MAX_ROWS];
	logic [1:0]  row_serves [MAX_ROWS];
	logic [31:0] row_vec0 [MAX_ROWS];
	logic [31:0] row_vec1 [MAX_ROWS];
	logic [1:0]  row_pend [MAX_ROWS];
	int          n_rows;

	logic [31:0] lfsr_state;
	logic [31:0] last_resume;
	logic [31:0] last_base;
	logic [1:0]  last_en;
	int          cycles;
	int          limit;

	int_ctrl_top #(
		.DRAIN_CYCLES (DRAIN)
	) UUT (
		.clk (clk), .rst (rst), .spart_int (spart_int), .spu_int (spu_int),
		.pc_curr (pc_curr), .take_branch (take_branch), .pc_branch (pc_branch),
		.instruction (instruction), .psel (psel), .penable (penable), .pwrite (pwrite),
		.paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
		.pslverr (pslverr), .pc_int (pc_int), .pc_resume (pc_resume),
		.int_wait (int_wait), .int_run (int_run), .int_done (int_done)
	);

	always #20 clk = ~clk;

	task automatic add_row(input logic [1:0] pulse, en, clr, input logic [31:0] base,
		pc_c, input logic br, input logic [31:0] pc_b, handler, input int runs,
		input logic rnd, input logic [1:0] serves, input logic [31:0] vec0, vec1,
		input logic [1:0] pend);
		row_pulse[n_rows] = pulse;
		row_en[n_rows] = en;
		row_clr[n_rows] = clr;
		row_base[n_rows] = base;
		row_pc_c[n_rows] = pc_c;
		row_br[n_rows] = br;
		row_pc_b[n_rows] = pc_b;
		row_handler[n_rows] = handler;
		row_runs[n_rows] = runs;
		row_rnd[n_rows] = rnd;
		row_serves[n_rows] = serves;
		row_vec0[n_rows] = vec0;
		row_vec1[n_rows] = vec1;
		row_pend[n_rows] = pend;
		n_rows++;
	endtask

	`include "int_ctrl_table.svh"

	task automatic stop_fail();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_fail();
		end
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ LFSR_TAPS;
		end
		return b;
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		for (int i = 0; i < 32; i++) begin
			w[i] = lfsr_bit();
		end
		return w;
	endfunction

	// Move to the drive point of the next cycle
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	// Sample point well inside the cycle
	task automatic look();
		#10;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic err);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		step();
		penable = 1'b1;
		look();
		check_val("pready", pready, 1'b1);
		check_val("pslverr", pslverr, err);
		step();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp,
		input logic err);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		step();
		penable = 1'b1;
		look();
		check_val("pready", pready, 1'b1);
		check_val("pslverr", pslverr, err);
		check_val("prdata", prdata, exp);
		step();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// One interrupt from acceptance to return
	task automatic serve(input logic [31:0] exp_vec, handler, exp_resume,
		input int runs);
		int wait_cnt;
		look();
		while (int_wait !== 1'b1) begin
			step();
			look();
		end
		check_val("int_run", int_run, 1'b0);
		wait_cnt = 1;
		step();
		instruction = handler;
		look();
		check_val("pc_int", pc_int, exp_vec);
		check_val("int_wait", int_wait, 1'b1);
		check_val("pc_resume", pc_resume, exp_resume);
		wait_cnt++;
		step();
		look();
		check_val("int_wait", int_wait, 1'b1);
		wait_cnt++;
		step();
		instruction = '0;
		look();
		check_val("pc_int", pc_int, handler);
		while (int_wait === 1'b1) begin
			wait_cnt++;
			check_val("int_run", int_run, 1'b0);
			step();
			look();
		end
		check_val("int_wait cycles", wait_cnt, 3 + DRAIN);
		for (int k = 0; k < runs; k++) begin
			if (k > 0) begin
				look();
			end
			check_val("int_run", int_run, 1'b1);
			check_val("int_done", int_done, 1'b0);
			step();
		end
		instruction = RETI_WORD;
		look();
		check_val("int_done", int_done, 1'b1);
		check_val("int_run", int_run, 1'b1);
		// No new request is taken in the return cycle
		check_val("int_wait", int_wait, 1'b0);
		step();
		instruction = '0;
		look();
		check_val("int_done", int_done, 1'b0);
		check_val("int_run", int_run, 1'b0);
	endtask

	task automatic run_row(input int i);
		logic [31:0] pc_c;
		logic [31:0] pc_b;
		logic [31:0] handler;
		logic [31:0] exp_resume;
		pc_c = row_pc_c[i];
		pc_b = row_pc_b[i];
		handler = row_handler[i];
		if (row_rnd[i]) begin
			pc_c = rand_word();
			pc_b = rand_word();
			handler = rand_word();
		end
		exp_resume = row_br[i] ? pc_b : pc_c;
		last_base = {row_base[i][31:2], 2'b00};
		apb_write(int_reg_pkg::REG_VEC_BASE, row_base[i], 1'b0);
		apb_read(int_reg_pkg::REG_VEC_BASE, last_base, 1'b0);
		if (row_clr[i] != 2'b00) begin
			apb_write(int_reg_pkg::REG_PENDING, {30'd0, row_clr[i]}, 1'b0);
		end
		apb_write(int_reg_pkg::REG_ENABLE, {30'd0, row_en[i]}, 1'b0);
		last_en = row_en[i];
		pc_curr = pc_c;
		pc_branch = pc_b;
		take_branch = row_br[i];
		spart_int = row_pulse[i][int_reg_pkg::SRC_SPART];
		spu_int = row_pulse[i][int_reg_pkg::SRC_SPU];
		step();
		spart_int = 1'b0;
		spu_int = 1'b0;
		if (row_serves[i] == 2'd0) begin
			repeat (6) begin
				look();
				check_val("int_wait", int_wait, 1'b0);
				step();
			end
		end else begin
			serve(row_vec0[i], handler, exp_resume, row_runs[i]);
			if (row_serves[i] == 2'd2) begin
				serve(row_vec1[i], handler, exp_resume, row_runs[i]);
			end
			last_resume = exp_resume;
			step();
		end
		take_branch = 1'b0;
		apb_read(int_reg_pkg::REG_PENDING, {30'd0, row_pend[i]}, 1'b0);
		apb_read(int_reg_pkg::REG_RESUME, last_resume, 1'b0);
		apb_read(int_reg_pkg::REG_ENABLE, {30'd0, last_en}, 1'b0);
	endtask

	// Watchdog on the total cycle count
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			stop_fail();
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		spart_int = 1'b0;
		spu_int = 1'b0;
		pc_curr = '0;
		take_branch = 1'b0;
		pc_branch = '0;
		instruction = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsr_state = 32'hfbad_f683;
		last_resume = '0;
		last_en = 2'b00;
		cycles = 0;
		n_rows = 0;
		load_table();
		limit = 8 + 40;
		for (int i = 0; i < n_rows; i++) begin
			limit += row_serves[i] * (12 + DRAIN + row_runs[i]) + 24;
		end
		limit = limit * 2;

		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		// State out of reset
		look();
		check_val("int_wait", int_wait, 1'b0);
		check_val("int_run", int_run, 1'b0);
		check_val("int_done", int_done, 1'b0);
		check_val("pslverr", pslverr, 1'b0);
		check_val("pc_resume", pc_resume, 32'h0);
		step();
		apb_read(int_reg_pkg::REG_PENDING, 32'h0, 1'b0);
		apb_read(int_reg_pkg::REG_VEC_BASE, 32'h0000_0008, 1'b0);
		apb_read(int_reg_pkg::REG_ENABLE, 32'h0, 1'b0);
		apb_read(int_reg_pkg::REG_RESUME, 32'h0, 1'b0);

		for (int i = 0; i < n_rows; i++) begin
			run_row(i);
		end

		// Bad accesses leave every register alone
		apb_write(8'h10, 32'hffff_ffff, 1'b1);
		apb_write(8'h09, 32'hffff_ff00, 1'b1);
		apb_write(int_reg_pkg::REG_RESUME, 32'h1234_5678, 1'b1);
		apb_read(8'h14, 32'h0, 1'b1);
		apb_read(int_reg_pkg::REG_RESUME, last_resume, 1'b0);
		apb_read(int_reg_pkg::REG_ENABLE, {30'd0, last_en}, 1'b0);
		apb_read(int_reg_pkg::REG_VEC_BASE, last_base, 1'b0);
		apb_read(int_reg_pkg::REG_PENDING, 32'h0, 1'b0);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: src.f
+incdir+tests
rtl/isa_pkg.sv
rtl/int_reg_pkg.sv
rtl/int_apb_regs.sv
rtl/int_fsm.sv
rtl/drain_timer.sv
rtl/int_capture.sv
rtl/int_ctrl_top.sv
tests/int_ctrl_tb.sv

// File: Bender.yml
package:
  name: int_ctrl

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/int_reg_pkg.sv
      - rtl/int_apb_regs.sv
      - rtl/int_fsm.sv
      - rtl/drain_timer.sv
      - rtl/int_capture.sv
      - rtl/int_ctrl_top.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/int_ctrl_tb.sv
